// ==== all.f ====
source/tinker_pkg.sv
source/fetch_decode.sv
source/register_file.sv
source/execute_stage.sv
source/memory_result.sv
source/tinker_core.sv
test/tinker_properties.sv
test/tinker_tb.sv

// ==== Bender.yml ====
package:
  name: tinker_core

sources:
  - source/tinker_pkg.sv
  - source/fetch_decode.sv
  - source/register_file.sv
  - source/execute_stage.sv
  - source/memory_result.sv
  - source/tinker_core.sv
  - target: test
    files:
      - test/tinker_properties.sv
      - test/tinker_tb.sv

// ==== test/tinker_tb.sv ====
module tinker_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // all tests take about 750 cycles, most of them in the random rounds
    localparam int max_cycles = 2000;

    logic                                      clk;
    logic                                      reset;
    logic                                      prog_we;
    logic [$clog2(tinker_pkg::imem_words)-1:0] prog_addr;
    logic [tinker_pkg::ilen-1:0]               prog_data;
    logic                                      dbg_req;
    logic [tinker_pkg::reg_addr_w-1:0]         dbg_addr;
    logic                                      dbg_ack;
    logic [tinker_pkg::xlen-1:0]               dbg_data;
    logic                                      hlt;

    logic [tinker_pkg::ilen-1:0] prog [$];                              // words to load
    logic [tinker_pkg::xlen-1:0] model [2**tinker_pkg::reg_addr_w];     // expected regs
    logic [tinker_pkg::xlen-1:0] model_mem [logic [tinker_pkg::xlen-1:0]];  // by word index
    logic                        halted;       // model ignores code after halt
    logic [31:0]                 lcg_state = 32'hacc0;
    int                          cycle_count = 0;

    tinker_core u_dut (
        .clk, .reset, .prog_we, .prog_addr, .prog_data,
        .dbg_req, .dbg_addr, .dbg_ack, .dbg_data, .hlt
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 100 MHz
    end

    // whole-run watchdog
    initial begin
        while (cycle_count < max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", max_cycles);
        $display("SIMULATION FAILED");
        $fatal(1);
    end

    // bound checker counts its failed assertions
    always @(posedge clk) begin
        if (u_dut.u_properties.violations != 0) begin
            $display("a bound assertion on the debug port or on hlt failed");
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_equal(input logic [63:0] got, exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    // empty program and model at reset values
    task automatic new_program();
        prog.delete();
        model_mem.delete();
        foreach (model[i]) begin
            model[i] = '0;
        end
        model[31] = tinker_pkg::sp_reset;  // stack pointer
        halted = 1'b0;
    endtask

    // assemble one instruction and step the in-order model
    task automatic emit(input logic [tinker_pkg::op_w-1:0] op,
                        input logic [tinker_pkg::reg_addr_w-1:0] rd, rs, rt,
                        input logic [tinker_pkg::lit_w-1:0] lit);
        logic [tinker_pkg::xlen-1:0] zl;
        logic [tinker_pkg::xlen-1:0] sl;
        logic [tinker_pkg::xlen-1:0] r;
        zl = lit;  // unsigned so it zero-extends
        sl = {{(tinker_pkg::xlen - tinker_pkg::lit_w){lit[tinker_pkg::lit_w-1]}}, lit};
        r  = model[rd];  // store and halt leave rd alone
        prog.push_back({op, rd, rs, rt, lit});
        if (!halted) begin
            case (op)
                tinker_pkg::op_and:    r = model[rs] & model[rt];
                tinker_pkg::op_or:     r = model[rs] | model[rt];
                tinker_pkg::op_xor:    r = model[rs] ^ model[rt];
                tinker_pkg::op_not:    r = ~model[rs];
                tinker_pkg::op_shftr:  r = model[rs] >> model[rt];
                tinker_pkg::op_shftri: r = model[rd] >> zl;
                tinker_pkg::op_shftl:  r = model[rs] << model[rt];
                tinker_pkg::op_shftli: r = model[rd] << zl;
                tinker_pkg::op_add:    r = model[rs] + model[rt];
                tinker_pkg::op_addi:   r = model[rd] + zl;
                tinker_pkg::op_sub:    r = model[rs] - model[rt];
                tinker_pkg::op_subi:   r = model[rd] - zl;
                tinker_pkg::op_mov_rr: r = model[rs];
                tinker_pkg::op_mov_rl: r[tinker_pkg::lit_w-1:0] = lit;  // upper bits kept
                tinker_pkg::op_load:   r = model_mem[(model[rs] + sl) >> 3];
                tinker_pkg::op_store:  model_mem[(model[rd] + sl) >> 3] = model[rs];
                default:               r = model[rd];
            endcase
            model[rd] = r;
        end
        if (op == tinker_pkg::op_halt) begin
            halted = 1'b1;
        end
    endtask

    // four-phase read on the debug port
    task automatic read_reg(input logic [tinker_pkg::reg_addr_w-1:0] addr,
                            output logic [tinker_pkg::xlen-1:0] value);
        @(posedge clk);
        dbg_req  <= 1'b1;
        dbg_addr <= addr;
        do begin
            @(negedge clk);
        end while (dbg_ack !== 1'b1);
        value = dbg_data;  // held while ack is high
        @(posedge clk);
        dbg_req <= 1'b0;
        do begin
            @(negedge clk);
        end while (dbg_ack !== 1'b0);
    endtask

    // reset, load, release, wait for hlt, then compare r0 up to last
    task automatic run_program(input int last);
        int                          held;
        logic [tinker_pkg::xlen-1:0] value;
        @(posedge clk);
        reset <= 1'b1;
        held = 0;
        foreach (prog[i]) begin
            prog_we   <= 1'b1;
            prog_addr <= i[$clog2(tinker_pkg::imem_words)-1:0];
            prog_data <= prog[i];
            @(posedge clk);
            held++;
        end
        prog_we <= 1'b0;
        while (held < 5) begin  // at least 5 cycles of reset
            @(posedge clk);
            held++;
        end
        reset <= 1'b0;
        @(negedge clk);
        check_equal(hlt, 1'b0, "hlt after reset");  // nothing retired yet
        check_equal(dbg_ack, 1'b0, "dbg_ack after reset");
        do begin
            @(negedge clk);
        end while (hlt !== 1'b1);
        for (int a = 0; a <= last; a++) begin
            read_reg(a[tinker_pkg::reg_addr_w-1:0], value);
            check_equal(value, model[a], $sformatf("r%0d", a));
        end
    endtask

    task automatic reset_values();
        new_program();
        emit(tinker_pkg::op_halt, 0, 0, 0, 0);
        run_program(31);  // r31 keeps sp_reset
    endtask

    // every step feeds the next through forwarding on rs, rt and rd
    task automatic alu_chain();
        new_program();
        emit(tinker_pkg::op_mov_rl, 10, 0, 0, 12'h005);  // shift amount
        emit(tinker_pkg::op_mov_rl, 1, 0, 0, 12'h7a5);
        emit(tinker_pkg::op_addi,   1, 0, 0, 12'hf23);   // top literal bit set
        emit(tinker_pkg::op_subi,   1, 0, 0, 12'h801);
        emit(tinker_pkg::op_add,    2, 1, 1, 0);
        emit(tinker_pkg::op_sub,    3, 2, 1, 0);         // rt from mem/wb
        emit(tinker_pkg::op_and,    4, 3, 2, 0);
        emit(tinker_pkg::op_or,     5, 4, 1, 0);
        emit(tinker_pkg::op_xor,    6, 5, 2, 0);
        emit(tinker_pkg::op_not,    7, 6, 0, 0);
        emit(tinker_pkg::op_shftl,  8, 7, 10, 0);
        emit(tinker_pkg::op_shftli, 8, 0, 0, 12'h004);
        emit(tinker_pkg::op_shftr,  9, 8, 10, 0);
        emit(tinker_pkg::op_shftri, 9, 0, 0, 12'h003);
        emit(tinker_pkg::op_mov_rr, 11, 9, 0, 0);
        emit(tinker_pkg::op_halt,   0, 0, 0, 0);
        run_program(11);
    endtask

    task automatic store_load_stall();
        new_program();
        emit(tinker_pkg::op_mov_rl, 1, 0, 0, 12'h100);   // base address
        emit(tinker_pkg::op_mov_rl, 2, 0, 0, 12'habc);
        emit(tinker_pkg::op_shftli, 2, 0, 0, 12'h00c);
        emit(tinker_pkg::op_mov_rl, 2, 0, 0, 12'h123);   // low bits only
        emit(tinker_pkg::op_store,  1, 2, 0, 12'h008);
        emit(tinker_pkg::op_load,   3, 1, 0, 12'h008);
        emit(tinker_pkg::op_add,    4, 3, 3, 0);         // load-use on rs and rt
        emit(tinker_pkg::op_load,   5, 1, 0, 12'h008);
        emit(tinker_pkg::op_addi,   5, 0, 0, 12'h001);   // load-use on rd
        emit(tinker_pkg::op_store,  1, 4, 0, 12'hff8);   // negative offset
        emit(tinker_pkg::op_load,   6, 1, 0, 12'hff8);
        emit(tinker_pkg::op_halt,   0, 0, 0, 0);
        run_program(6);
    endtask

    task automatic halt_stops_program();
        new_program();
        emit(tinker_pkg::op_mov_rl, 1, 0, 0, 12'h011);
        emit(tinker_pkg::op_halt,   0, 0, 0, 0);
        emit(tinker_pkg::op_mov_rl, 1, 0, 0, 12'h022);   // never retires
        emit(tinker_pkg::op_mov_rl, 2, 0, 0, 12'h033);
        emit(tinker_pkg::op_addi,   3, 0, 0, 12'h005);
        run_program(3);
        repeat (8) begin
            @(negedge clk);
            check_equal(hlt, 1'b1, "hlt after halt");  // sticky
        end
    endtask

    task automatic random_operands();
        logic [31:0]                  rnd;
        logic [tinker_pkg::lit_w-1:0] a;
        logic [tinker_pkg::lit_w-1:0] b;
        for (int round = 0; round < 10; round++) begin
            rnd = next_rand();
            a   = rnd[31:20];  // upper lcg bits
            rnd = next_rand();
            b   = rnd[31:20];
            new_program();
            emit(tinker_pkg::op_mov_rl, 1, 0, 0, a);
            emit(tinker_pkg::op_mov_rl, 2, 0, 0, b);
            emit(tinker_pkg::op_add,    3, 1, 2, 0);
            emit(tinker_pkg::op_sub,    4, 1, 2, 0);     // may wrap below zero
            emit(tinker_pkg::op_xor,    5, 1, 2, 0);
            emit(tinker_pkg::op_halt,   0, 0, 0, 0);
            run_program(5);
        end
    endtask

    initial begin
        reset     = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        dbg_req   = 1'b0;
        dbg_addr  = '0;
        reset_values();
        alu_chain();
        store_load_stall();
        halt_stops_program();
        random_operands();
        if (u_dut.u_properties.violations != 0) begin
            $display("bound assertions failed %0d times", u_dut.u_properties.violations);
            $display("SIMULATION FAILED");
            $fatal(1);
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// ==== test/tinker_properties.sv ====
module tinker_properties (
    input logic                        clk,
    input logic                        reset,
    input logic                        dbg_req,
    input logic                        dbg_ack,
    input logic [tinker_pkg::xlen-1:0] dbg_data,
    input logic                        hlt
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned violations = 0;  // failed checks so far

    // ack answers a request seen the cycle before
    ack_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(dbg_ack) |-> $past(dbg_req))
        else begin
            violations++;
            $error("dbg_ack rose with no request pending");
        end

    // ack drops only once req is gone
    ack_fall: assert property (@(posedge clk) disable iff (reset)
        $fell(dbg_ack) |-> !$past(dbg_req))
        else begin
            violations++;
            $error("dbg_ack fell while the request was still high");
        end

    data_hold: assert property (@(posedge clk) disable iff (reset)
        dbg_ack && $past(dbg_ack) |-> $stable(dbg_data))
        else begin
            violations++;
            $error("dbg_data changed while dbg_ack was high");
        end

    // halt flag only cleared by reset
    hlt_sticky: assert property (@(posedge clk) $fell(hlt) |-> reset)
        else begin
            violations++;
            $error("hlt fell without reset");
        end

endmodule

bind tinker_core tinker_properties u_properties (
    .clk(clk),
    .reset(reset),
    .dbg_req(dbg_req),
    .dbg_ack(dbg_ack),
    .dbg_data(dbg_data),
    .hlt(hlt)
);

// ==== source/tinker_core.sv ====
module tinker_core (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  prog_we,
    input  logic [$clog2(tinker_pkg::imem_words)-1:0] prog_addr,
    input  logic [tinker_pkg::ilen-1:0]           prog_data,
    input  logic                                  dbg_req,
    input  logic [tinker_pkg::reg_addr_w-1:0]     dbg_addr,
    output logic                                  dbg_ack,
    output logic [tinker_pkg::xlen-1:0]           dbg_data,
    output logic                                  hlt
);

    // decode to register file
    logic [tinker_pkg::reg_addr_w-1:0] rd_addr, rs_addr, rt_addr;
    logic [tinker_pkg::xlen-1:0]       rd_data, rs_data, rt_data;

    // id/ex outputs
    tinker_pkg::ctrl_t                 ex_ctrl;
    logic [tinker_pkg::op_w-1:0]       ex_op;
    logic [tinker_pkg::reg_addr_w-1:0] ex_rd, ex_rs, ex_rt;
    logic [tinker_pkg::lit_w-1:0]      ex_lit;
    logic [tinker_pkg::xlen-1:0]       ex_rd_val, ex_rs_val, ex_rt_val;

    // ex/mem outputs
    tinker_pkg::ctrl_t                 mem_ctrl;
    logic [tinker_pkg::reg_addr_w-1:0] mem_dest;
    logic [tinker_pkg::xlen-1:0]       mem_alu, mem_store_val;

    // writeback, also the older forwarding source
    logic                              wb_we;
    logic [tinker_pkg::reg_addr_w-1:0] wb_dest;
    logic [tinker_pkg::xlen-1:0]       wb_data;

    fetch_decode u_fetch_decode (
        .clk, .reset, .prog_we, .prog_addr, .prog_data,
        .rd_data, .rs_data, .rt_data,
        .rd_addr, .rs_addr, .rt_addr,
        .ex_ctrl, .ex_op, .ex_rd, .ex_rs, .ex_rt, .ex_lit,
        .ex_rd_val, .ex_rs_val, .ex_rt_val
    );

    register_file u_register_file (
        .clk, .reset, .rd_addr, .rs_addr, .rt_addr,
        .wb_we, .wb_dest, .wb_data,
        .dbg_req, .dbg_addr,
        .rd_data, .rs_data, .rt_data,
        .dbg_ack, .dbg_data
    );

    execute_stage u_execute_stage (
        .clk, .reset,
        .ex_ctrl, .ex_op, .ex_rd, .ex_rs, .ex_rt, .ex_lit,
        .ex_rd_val, .ex_rs_val, .ex_rt_val,
        .wb_we, .wb_dest, .wb_data,
        .mem_ctrl, .mem_dest, .mem_alu, .mem_store_val
    );

    memory_result u_memory_result (
        .clk, .reset,
        .mem_ctrl, .mem_dest, .mem_alu, .mem_store_val,
        .wb_we, .wb_dest, .wb_data, .hlt
    );

endmodule

// ==== source/memory_result.sv ====
module memory_result (
    input  logic                              clk,
    input  logic                              reset,
    input  tinker_pkg::ctrl_t                 mem_ctrl,
    input  logic [tinker_pkg::reg_addr_w-1:0] mem_dest,
    input  logic [tinker_pkg::xlen-1:0]       mem_alu,
    input  logic [tinker_pkg::xlen-1:0]       mem_store_val,
    output logic                              wb_we,
    output logic [tinker_pkg::reg_addr_w-1:0] wb_dest,
    output logic [tinker_pkg::xlen-1:0]       wb_data,
    output logic                              hlt
);

    logic [tinker_pkg::xlen-1:0]               dmem [tinker_pkg::dmem_words];
    logic [$clog2(tinker_pkg::dmem_words)-1:0] dmem_idx;   // 8-byte word index
    logic [tinker_pkg::xlen-1:0]               load_data;
    tinker_pkg::ctrl_t                         wb_ctrl;    // mem/wb control
    logic [tinker_pkg::xlen-1:0]               wb_alu;
    logic [tinker_pkg::xlen-1:0]               wb_load;

    // low three address bits dropped
    assign dmem_idx  = mem_alu[$clog2(tinker_pkg::dmem_words)+2:3];
    assign load_data = dmem[dmem_idx];  // same-cycle read

    always_ff @(posedge clk) begin
        if (mem_ctrl.mem_write) begin
            dmem[dmem_idx] <= mem_store_val;
        end
    end

    // mem/wb register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_ctrl <= '0;
            hlt     <= 1'b0;
        end else begin
            wb_ctrl <= mem_ctrl;
            if (mem_ctrl.halt) begin
                hlt <= 1'b1;  // sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_dest <= mem_dest;
        wb_alu  <= mem_alu;
        wb_load <= load_data;
    end

    // writeback select
    assign wb_we   = wb_ctrl.reg_write;
    assign wb_data = wb_ctrl.mem_to_reg ? wb_load : wb_alu;

endmodule

// ==== source/execute_stage.sv ====
module execute_stage (
    input  logic                              clk,
    input  logic                              reset,
    input  tinker_pkg::ctrl_t                 ex_ctrl,
    input  logic [tinker_pkg::op_w-1:0]       ex_op,
    input  logic [tinker_pkg::reg_addr_w-1:0] ex_rd,
    input  logic [tinker_pkg::reg_addr_w-1:0] ex_rs,
    input  logic [tinker_pkg::reg_addr_w-1:0] ex_rt,
    input  logic [tinker_pkg::lit_w-1:0]      ex_lit,
    input  logic [tinker_pkg::xlen-1:0]       ex_rd_val,
    input  logic [tinker_pkg::xlen-1:0]       ex_rs_val,
    input  logic [tinker_pkg::xlen-1:0]       ex_rt_val,
    input  logic                              wb_we,
    input  logic [tinker_pkg::reg_addr_w-1:0] wb_dest,
    input  logic [tinker_pkg::xlen-1:0]       wb_data,
    output tinker_pkg::ctrl_t                 mem_ctrl,
    output logic [tinker_pkg::reg_addr_w-1:0] mem_dest,
    output logic [tinker_pkg::xlen-1:0]       mem_alu,
    output logic [tinker_pkg::xlen-1:0]       mem_store_val
);

    logic [tinker_pkg::xlen-1:0] rd_f;     // forwarded operands
    logic [tinker_pkg::xlen-1:0] rs_f;
    logic [tinker_pkg::xlen-1:0] rt_f;
    logic [tinker_pkg::xlen-1:0] lit_z;    // zero-extended literal
    logic [tinker_pkg::xlen-1:0] lit_s;    // sign-extended literal
    logic [tinker_pkg::xlen-1:0] alu_out;

    // newest copy of a register, ex/mem wins over mem/wb
    function automatic logic [tinker_pkg::xlen-1:0] newest(
        input logic [tinker_pkg::reg_addr_w-1:0] addr,
        input logic [tinker_pkg::xlen-1:0]       reg_val
    );
        if (mem_ctrl.reg_write && mem_dest == addr) begin
            return mem_alu;
        end
        if (wb_we && wb_dest == addr) begin
            return wb_data;  // includes load data
        end
        return reg_val;
    endfunction

    always_comb begin
        rd_f = newest(ex_rd, ex_rd_val);
        rs_f = newest(ex_rs, ex_rs_val);
        rt_f = newest(ex_rt, ex_rt_val);
    end

    assign lit_z = {{(tinker_pkg::xlen-tinker_pkg::lit_w){1'b0}}, ex_lit};
    assign lit_s = {{(tinker_pkg::xlen-tinker_pkg::lit_w){ex_lit[tinker_pkg::lit_w-1]}}, ex_lit};

    always_comb begin
        alu_out = '0;  // halt and bubbles
        case (ex_op)
            tinker_pkg::op_add:    alu_out = rs_f + rt_f;
            tinker_pkg::op_addi:   alu_out = rd_f + lit_z;
            tinker_pkg::op_sub:    alu_out = rs_f - rt_f;
            tinker_pkg::op_subi:   alu_out = rd_f - lit_z;
            tinker_pkg::op_and:    alu_out = rs_f & rt_f;
            tinker_pkg::op_or:     alu_out = rs_f | rt_f;
            tinker_pkg::op_xor:    alu_out = rs_f ^ rt_f;
            tinker_pkg::op_not:    alu_out = ~rs_f;
            tinker_pkg::op_shftr:  alu_out = rs_f >> rt_f;   // full-width amount
            tinker_pkg::op_shftri: alu_out = rd_f >> lit_z;
            tinker_pkg::op_shftl:  alu_out = rs_f << rt_f;
            tinker_pkg::op_shftli: alu_out = rd_f << lit_z;
            tinker_pkg::op_mov_rr: alu_out = rs_f;
            tinker_pkg::op_mov_rl: begin
                alu_out = rd_f;
                alu_out[tinker_pkg::lit_w-1:0] = ex_lit;  // upper bits kept
            end
            tinker_pkg::op_load:   alu_out = rs_f + lit_s;  // byte address
            tinker_pkg::op_store:  alu_out = rd_f + lit_s;
            default:               alu_out = '0;
        endcase
    end

    // ex/mem register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_ctrl <= '0;
        end else begin
            mem_ctrl <= ex_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        mem_dest      <= ex_rd;
        mem_alu       <= alu_out;
        mem_store_val <= rs_f;  // store data is rs
    end

endmodule

// ==== source/register_file.sv ====
module register_file (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [tinker_pkg::reg_addr_w-1:0] rd_addr,
    input  logic [tinker_pkg::reg_addr_w-1:0] rs_addr,
    input  logic [tinker_pkg::reg_addr_w-1:0] rt_addr,
    input  logic                              wb_we,
    input  logic [tinker_pkg::reg_addr_w-1:0] wb_dest,
    input  logic [tinker_pkg::xlen-1:0]       wb_data,
    input  logic                              dbg_req,
    input  logic [tinker_pkg::reg_addr_w-1:0] dbg_addr,
    output logic [tinker_pkg::xlen-1:0]       rd_data,
    output logic [tinker_pkg::xlen-1:0]       rs_data,
    output logic [tinker_pkg::xlen-1:0]       rt_data,
    output logic                              dbg_ack,
    output logic [tinker_pkg::xlen-1:0]       dbg_data
);

    logic [tinker_pkg::xlen-1:0] regs [2**tinker_pkg::reg_addr_w];

    // stored value, or the one being written this cycle
    function automatic logic [tinker_pkg::xlen-1:0] read_port(
        input logic [tinker_pkg::reg_addr_w-1:0] addr
    );
        if (wb_we && wb_dest == addr) begin
            return wb_data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**tinker_pkg::reg_addr_w; i++) begin
                regs[i] <= '0;
            end
            regs[31] <= tinker_pkg::sp_reset;  // stack pointer
        end else if (wb_we) begin
            regs[wb_dest] <= wb_data;
        end
    end

    // decode reads
    always_comb begin
        rd_data = read_port(rd_addr);
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

    // debug port, ack low = idle, ack high = data held
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dbg_ack <= 1'b0;
        end else if (!dbg_ack && dbg_req) begin
            dbg_ack <= 1'b1;
        end else if (dbg_ack && !dbg_req) begin
            dbg_ack <= 1'b0;  // requester let go
        end
    end

    always_ff @(posedge clk) begin
        if (!dbg_ack && dbg_req) begin
            dbg_data <= read_port(dbg_addr);  // frozen until next request
        end
    end

endmodule

// ==== source/fetch_decode.sv ====
module fetch_decode (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  prog_we,
    input  logic [$clog2(tinker_pkg::imem_words)-1:0] prog_addr,
    input  logic [tinker_pkg::ilen-1:0]           prog_data,
    input  logic [tinker_pkg::xlen-1:0]           rd_data,
    input  logic [tinker_pkg::xlen-1:0]           rs_data,
    input  logic [tinker_pkg::xlen-1:0]           rt_data,
    output logic [tinker_pkg::reg_addr_w-1:0]     rd_addr,
    output logic [tinker_pkg::reg_addr_w-1:0]     rs_addr,
    output logic [tinker_pkg::reg_addr_w-1:0]     rt_addr,
    output tinker_pkg::ctrl_t                     ex_ctrl,
    output logic [tinker_pkg::op_w-1:0]           ex_op,
    output logic [tinker_pkg::reg_addr_w-1:0]     ex_rd,
    output logic [tinker_pkg::reg_addr_w-1:0]     ex_rs,
    output logic [tinker_pkg::reg_addr_w-1:0]     ex_rt,
    output logic [tinker_pkg::lit_w-1:0]          ex_lit,
    output logic [tinker_pkg::xlen-1:0]           ex_rd_val,
    output logic [tinker_pkg::xlen-1:0]           ex_rs_val,
    output logic [tinker_pkg::xlen-1:0]           ex_rt_val
);

    logic [tinker_pkg::ilen-1:0]       imem [tinker_pkg::imem_words];
    logic [31:0]                       pc;
    logic [31:0]                       pc_off;      // byte offset from reset pc
    logic [tinker_pkg::ilen-1:0]       if_instr;
    logic [tinker_pkg::ilen-1:0]       id_instr;    // if/id payload
    logic                              id_valid;    // if/id holds a real instruction
    logic                              fetch_stop;  // halt already passed decode
    logic [tinker_pkg::op_w-1:0]       id_op;
    logic [tinker_pkg::reg_addr_w-1:0] id_rd;
    logic [tinker_pkg::reg_addr_w-1:0] id_rs;
    logic [tinker_pkg::reg_addr_w-1:0] id_rt;
    logic [tinker_pkg::lit_w-1:0]      id_lit;
    tinker_pkg::ctrl_t                 id_ctrl;
    logic                              stall;       // load-use hold
    logic                              freeze;      // no more fetch after halt

    // program port, only open while reset is held
    always_ff @(posedge clk) begin
        if (reset && prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    assign pc_off   = pc - tinker_pkg::pc_reset;
    assign if_instr = imem[pc_off[$clog2(tinker_pkg::imem_words)+1:2]];  // word index

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= tinker_pkg::pc_reset;
        end else if (!stall && !freeze) begin
            pc <= pc + 32'd4;
        end
    end

    // if/id valid and halt latch
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_valid   <= 1'b0;
            fetch_stop <= 1'b0;
        end else if (!stall) begin
            id_valid <= !freeze;  // bubbles once halt is decoded
            if (id_ctrl.halt) begin
                fetch_stop <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            id_instr <= if_instr;
        end
    end

    // field split
    assign id_op  = id_instr[31:27];
    assign id_rd  = id_instr[26:22];
    assign id_rs  = id_instr[21:17];
    assign id_rt  = id_instr[16:12];
    assign id_lit = id_instr[11:0];

    assign rd_addr = id_rd;
    assign rs_addr = id_rs;
    assign rt_addr = id_rt;

    always_comb begin
        id_ctrl = '0;
        if (id_valid) begin
            case (id_op)
                tinker_pkg::op_add, tinker_pkg::op_sub,
                tinker_pkg::op_and, tinker_pkg::op_or, tinker_pkg::op_xor,
                tinker_pkg::op_not, tinker_pkg::op_shftr, tinker_pkg::op_shftl,
                tinker_pkg::op_mov_rr: begin
                    id_ctrl.reg_write = 1'b1;
                end
                tinker_pkg::op_addi, tinker_pkg::op_subi, tinker_pkg::op_shftri,
                tinker_pkg::op_shftli, tinker_pkg::op_mov_rl: begin
                    id_ctrl.reg_write = 1'b1;
                    id_ctrl.uses_rd   = 1'b1;  // rd is also the left operand
                end
                tinker_pkg::op_load: begin
                    id_ctrl.reg_write  = 1'b1;
                    id_ctrl.mem_read   = 1'b1;
                    id_ctrl.mem_to_reg = 1'b1;
                end
                tinker_pkg::op_store: begin
                    id_ctrl.mem_write = 1'b1;
                    id_ctrl.uses_rd   = 1'b1;  // base address
                end
                tinker_pkg::op_halt: id_ctrl.halt = 1'b1;
                default: id_ctrl = '0;  // unknown opcode drops out
            endcase
        end
    end

    // load in ex feeding any source of the instruction in id
    assign stall = id_valid && ex_ctrl.mem_read &&
                   (ex_rd == id_rs || ex_rd == id_rt || (id_ctrl.uses_rd && ex_rd == id_rd));
    assign freeze = fetch_stop || id_ctrl.halt;

    // id/ex control, bubble on stall
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_ctrl <= '0;
        end else if (stall) begin
            ex_ctrl <= '0;
        end else begin
            ex_ctrl <= id_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        ex_op     <= id_op;
        ex_rd     <= id_rd;
        ex_rs     <= id_rs;
        ex_rt     <= id_rt;
        ex_lit    <= id_lit;
        ex_rd_val <= rd_data;
        ex_rs_val <= rs_data;
        ex_rt_val <= rt_data;
    end

endmodule

// ==== source/tinker_pkg.sv ====
package tinker_pkg;

    // datapath widths
    localparam int xlen       = 64;  // register and data word
    localparam int ilen       = 32;  // one instruction word
    localparam int reg_addr_w = 5;   // 32 registers
    localparam int lit_w      = 12;  // literal field
    localparam int op_w       = 5;   // opcode field

    // reset values
    localparam logic [31:0]   pc_reset = 32'h2000;   // first fetch
    localparam logic [xlen-1:0] sp_reset = 64'h80000;  // r31 after reset

    // memory sizes
    localparam int imem_words = 1024;  // 32-bit instruction words
    localparam int dmem_words = 512;   // 64-bit data words

    // logic group
    localparam logic [op_w-1:0] op_and    = 5'h00;
    localparam logic [op_w-1:0] op_or     = 5'h01;
    localparam logic [op_w-1:0] op_xor    = 5'h02;
    localparam logic [op_w-1:0] op_not    = 5'h03;  // rt ignored

    // shifts
    localparam logic [op_w-1:0] op_shftr  = 5'h04;
    localparam logic [op_w-1:0] op_shftri = 5'h05;  // rd >> L
    localparam logic [op_w-1:0] op_shftl  = 5'h06;
    localparam logic [op_w-1:0] op_shftli = 5'h07;  // rd << L

    // halt sits between the branch codes, which are not decoded here
    localparam logic [op_w-1:0] op_halt   = 5'h0f;

    // data movement
    localparam logic [op_w-1:0] op_load   = 5'h10;  // mov rd, (rs)(L)
    localparam logic [op_w-1:0] op_mov_rr = 5'h11;  // mov rd, rs
    localparam logic [op_w-1:0] op_mov_rl = 5'h12;  // mov rd, L
    localparam logic [op_w-1:0] op_store  = 5'h13;  // mov (rd)(L), rs

    // integer arithmetic
    localparam logic [op_w-1:0] op_add    = 5'h18;
    localparam logic [op_w-1:0] op_addi   = 5'h19;  // rd + L
    localparam logic [op_w-1:0] op_sub    = 5'h1a;
    localparam logic [op_w-1:0] op_subi   = 5'h1b;  // rd - L

    // control bits carried down the pipe
    // all zero means bubble
    typedef struct packed {
        logic reg_write;   // writes rd at wb
        logic mem_read;    // load in mem stage
        logic mem_write;   // store in mem stage
        logic mem_to_reg;  // wb takes load data
        logic halt;        // stop fetch, raise hlt
        logic uses_rd;     // rd is a source operand too
    } ctrl_t;

endpackage
